/* source/soc_ifc_pkg.sv */
// Bus widths, address map, mailbox register offsets and bus structs for the SoC interface

package soc_ifc_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int USER_W = 8;

    // Address map, compared against the upper halfword of haddr
    localparam logic [15:0] LMEM_BASE = 16'h0000;
    localparam logic [15:0] MBOX_BASE = 16'h3000;

    // Mailbox register byte offsets
    localparam logic [3:0] REG_CMD  = 4'h0;
    localparam logic [3:0] REG_DATA = 4'h4;
    localparam logic [3:0] REG_RESP = 4'h8;
    localparam logic [3:0] REG_BOOT = 4'hC;

    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // --------------------
    // Bus structs
    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
        logic [USER_W-1:0] pauser;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        logic              pslverr;
        logic [DATA_W-1:0] prdata;
    } apb_rsp_t;

    // Address phase only, hwdata travels on its own
    typedef struct packed {
        logic [ADDR_W-1:0] haddr;
        logic [1:0]        htrans;
        logic              hwrite;
    } ahb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] hrdata;
        logic              hreadyout;
        logic              hresp;
    } ahb_rsp_t;

    // SEQ shares the upper htrans bit with NONSEQ
    function automatic logic htrans_valid(input logic [1:0] htrans);
        return (htrans & HTRANS_NONSEQ) == HTRANS_NONSEQ;
    endfunction

endpackage

/* source/ahb_addr_decoder.sv */
// AHB-lite address decoder with default error slave and data-phase response mux

module ahb_addr_decoder (
    input  logic                  core_clk,
    input  logic                  rst_n_i,
    input  soc_ifc_pkg::ahb_req_t ahb_req_i,
    output soc_ifc_pkg::ahb_rsp_t ahb_rsp_o,
    output logic                  hready_o,
    output logic                  lmem_sel_o,
    output logic                  mbox_sel_o,
    input  soc_ifc_pkg::ahb_rsp_t lmem_rsp_i,
    input  soc_ifc_pkg::ahb_rsp_t mbox_rsp_i
);
    import soc_ifc_pkg::*;

    typedef enum logic [1:0] {DP_NONE, DP_LMEM, DP_MBOX, DP_DEF} dp_owner_t;
    typedef enum logic {DEF_FIRST, DEF_SECOND} def_state_t;

    dp_owner_t  dp_owner_q;
    def_state_t def_state_q;
    logic       addr_valid;

    // Address phase decode
    assign lmem_sel_o = (ahb_req_i.haddr[ADDR_W-1:16] == LMEM_BASE);
    assign mbox_sel_o = (ahb_req_i.haddr[ADDR_W-1:16] == MBOX_BASE);
    assign addr_valid = htrans_valid(ahb_req_i.htrans);
    assign hready_o   = ahb_rsp_o.hreadyout;

    // Owner of the next data phase, captured when the bus is ready
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            dp_owner_q <= DP_NONE;
        end else if (hready_o) begin
            if (!addr_valid) begin
                dp_owner_q <= DP_NONE;
            end else if (lmem_sel_o) begin
                dp_owner_q <= DP_LMEM;
            end else if (mbox_sel_o) begin
                dp_owner_q <= DP_MBOX;
            end else begin
                dp_owner_q <= DP_DEF;
            end
        end
    end

    // --------------------
    // Default slave, first error cycle stalls and second one completes
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            def_state_q <= DEF_FIRST;
        end else if (dp_owner_q == DP_DEF && def_state_q == DEF_FIRST) begin
            def_state_q <= DEF_SECOND;
        end else begin
            def_state_q <= DEF_FIRST;
        end
    end

    // Response back to the master
    always_comb begin
        unique case (dp_owner_q)
            DP_LMEM: ahb_rsp_o = lmem_rsp_i;
            DP_MBOX: ahb_rsp_o = mbox_rsp_i;
            DP_DEF: begin
                ahb_rsp_o.hrdata    = '0;
                ahb_rsp_o.hreadyout = (def_state_q == DEF_SECOND);
                ahb_rsp_o.hresp     = 1'b1;
            end
            default: begin
                ahb_rsp_o.hrdata    = '0;
                ahb_rsp_o.hreadyout = 1'b1;
                ahb_rsp_o.hresp     = 1'b0;
            end
        endcase
    end

endmodule

/* source/ahb_lmem.sv */
// Zero-wait AHB-lite local word memory

module ahb_lmem #(
    parameter int LMEM_WORDS = 256
) (
    input  logic                                core_clk,
    input  logic                                rst_n_i,
    input  logic                                hsel_i,
    input  logic                                hready_i,
    input  soc_ifc_pkg::ahb_req_t               ahb_req_i,
    input  logic [soc_ifc_pkg::DATA_W-1:0]      hwdata_i,
    output soc_ifc_pkg::ahb_rsp_t               ahb_rsp_o
);
    import soc_ifc_pkg::*;

    localparam int IDX_W = (LMEM_WORDS > 1) ? $clog2(LMEM_WORDS) : 1;

    logic [DATA_W-1:0] mem [LMEM_WORDS];
    logic [IDX_W-1:0]  word_idx;
    logic [IDX_W-1:0]  dp_idx_q;
    logic              dp_valid_q;
    logic              dp_write_q;
    logic              accept;

    // Word index wraps over the memory depth
    assign word_idx = IDX_W'((ahb_req_i.haddr >> 2) % LMEM_WORDS);
    assign accept   = hsel_i && hready_i && htrans_valid(ahb_req_i.htrans);

    // Address phase capture
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            dp_valid_q <= 1'b0;
            dp_write_q <= 1'b0;
            dp_idx_q   <= '0;
        end else begin
            dp_valid_q <= accept;
            if (accept) begin
                dp_write_q <= ahb_req_i.hwrite;
                dp_idx_q   <= word_idx;
            end
        end
    end

    // Data phase write
    always_ff @(posedge core_clk) begin
        if (dp_valid_q && dp_write_q) begin
            mem[dp_idx_q] <= hwdata_i;
        end
    end

    assign ahb_rsp_o.hrdata    = mem[dp_idx_q];
    assign ahb_rsp_o.hreadyout = 1'b1;
    assign ahb_rsp_o.hresp     = 1'b0;

endmodule

/* source/mbox_regs.sv */
// Mailbox and boot-control registers with APB host side and AHB-lite uC side

module mbox_regs #(
    parameter logic [soc_ifc_pkg::USER_W-1:0] VALID_PAUSER = 8'h01
) (
    input  logic                           core_clk,
    input  logic                           rst_n_i,
    input  soc_ifc_pkg::apb_req_t          apb_req_i,
    output soc_ifc_pkg::apb_rsp_t          apb_rsp_o,
    input  logic                           hsel_i,
    input  logic                           hready_i,
    input  soc_ifc_pkg::ahb_req_t          ahb_req_i,
    input  logic [soc_ifc_pkg::DATA_W-1:0] hwdata_i,
    output soc_ifc_pkg::ahb_rsp_t          ahb_rsp_o,
    output logic                           boot_go_o,
    input  logic                           uc_released_i
);
    import soc_ifc_pkg::*;

    logic [DATA_W-1:0] cmd_q;
    logic [DATA_W-1:0] data_q;
    logic [DATA_W-1:0] resp_q;
    logic [3:0]        apb_off;
    logic              apb_access;
    logic              apb_hit;
    logic              apb_bad_wr;
    logic              apb_err;
    logic              apb_wr;
    logic              ahb_accept;
    logic              ahb_dp_valid_q;
    logic              ahb_dp_write_q;
    logic [3:0]        ahb_dp_off_q;

    // Register read mux shared by both buses
    function automatic logic [DATA_W-1:0] reg_read(
        input logic [3:0]        off,
        input logic [DATA_W-1:0] cmd,
        input logic [DATA_W-1:0] data,
        input logic [DATA_W-1:0] resp,
        input logic              released
    );
        case (off)
            REG_CMD:  return cmd;
            REG_DATA: return data;
            REG_RESP: return resp;
            REG_BOOT: return {{(DATA_W-1){1'b0}}, released};
            default:  return '0;
        endcase
    endfunction

    // --------------------
    // APB side
    assign apb_off    = apb_req_i.paddr[3:0];
    assign apb_access = apb_req_i.psel && apb_req_i.penable;
    assign apb_hit    = (apb_req_i.paddr[ADDR_W-1:4] == '0) &&
                        (apb_off inside {REG_CMD, REG_DATA, REG_RESP, REG_BOOT});
    // RESP belongs to the uC, and only the trusted PAUSER may write
    assign apb_bad_wr = apb_req_i.pwrite &&
                        ((apb_off == REG_RESP) || (apb_req_i.pauser != VALID_PAUSER));
    assign apb_err    = apb_access && (!apb_hit || apb_bad_wr);
    assign apb_wr     = apb_access && apb_req_i.pwrite && !apb_err;

    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = apb_err;
    assign apb_rsp_o.prdata  = apb_hit ? reg_read(apb_off, cmd_q, data_q, resp_q, uc_released_i)
                                       : '0;

    // Boot request pulse
    assign boot_go_o = apb_wr && (apb_off == REG_BOOT) && apb_req_i.pwdata[0];

    // --------------------
    // AHB side
    assign ahb_accept = hsel_i && hready_i && htrans_valid(ahb_req_i.htrans);

    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            ahb_dp_valid_q <= 1'b0;
            ahb_dp_write_q <= 1'b0;
            ahb_dp_off_q   <= '0;
        end else begin
            ahb_dp_valid_q <= ahb_accept;
            if (ahb_accept) begin
                ahb_dp_write_q <= ahb_req_i.hwrite;
                ahb_dp_off_q   <= ahb_req_i.haddr[3:0];
            end
        end
    end

    assign ahb_rsp_o.hrdata    = reg_read(ahb_dp_off_q, cmd_q, data_q, resp_q, uc_released_i);
    assign ahb_rsp_o.hreadyout = 1'b1;
    assign ahb_rsp_o.hresp     = 1'b0;

    // Mailbox registers
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            cmd_q  <= '0;
            data_q <= '0;
            resp_q <= '0;
        end else begin
            if (apb_wr && apb_off == REG_CMD) begin
                cmd_q <= apb_req_i.pwdata;
            end
            if (apb_wr && apb_off == REG_DATA) begin
                data_q <= apb_req_i.pwdata;
            end
            // uC writes land only in RESP
            if (ahb_dp_valid_q && ahb_dp_write_q && ahb_dp_off_q == REG_RESP) begin
                resp_q <= hwdata_i;
            end
        end
    end

endmodule

/* source/boot_seq_fsm.sv */
// Boot sequencer FSM holding the microcontroller in reset until a boot request

module boot_seq_fsm #(
    parameter int BOOT_DELAY = 16
) (
    input  logic core_clk,
    input  logic rst_n_i,
    input  logic boot_go_i,
    output logic uc_rst_n_o
);

    localparam int CNT_W = $clog2(BOOT_DELAY + 1);

    typedef enum logic [1:0] {BOOT_IDLE, BOOT_WAIT, BOOT_DONE} boot_state_t;

    boot_state_t      state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             uc_rst_n_q;

    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            state_q    <= BOOT_IDLE;
            cnt_q      <= '0;
            uc_rst_n_q <= 1'b0;
        end else begin
            unique case (state_q)
                BOOT_IDLE: begin
                    if (boot_go_i) begin
                        state_q <= BOOT_WAIT;
                        cnt_q   <= CNT_W'(BOOT_DELAY - 1);
                    end
                end
                BOOT_WAIT: begin
                    // Release lands on the BOOT_DELAY-th edge after the request
                    if (cnt_q == '0) begin
                        state_q    <= BOOT_DONE;
                        uc_rst_n_q <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    // Stays released until the next reset
                    state_q <= BOOT_DONE;
                end
            endcase
        end
    end

    assign uc_rst_n_o = uc_rst_n_q;

endmodule

/* source/soc_ifc_top.sv */
// SoC interface top level with AHB decoder, local memory, mailbox and boot sequencer

module soc_ifc_top (
    input  logic                           core_clk,
    input  logic                           rst_n_i,
    input  soc_ifc_pkg::apb_req_t          apb_req_i,
    output soc_ifc_pkg::apb_rsp_t          apb_rsp_o,
    input  soc_ifc_pkg::ahb_req_t          ahb_req_i,
    input  logic [soc_ifc_pkg::DATA_W-1:0] hwdata_i,
    output soc_ifc_pkg::ahb_rsp_t          ahb_rsp_o,
    output logic                           uc_rst_n_o
);
    import soc_ifc_pkg::*;

    localparam int               LMEM_WORDS   = 256;
    localparam int               BOOT_DELAY   = 16;
    localparam logic [USER_W-1:0] VALID_PAUSER = 8'h01;

    logic     hready;
    logic     lmem_sel;
    logic     mbox_sel;
    logic     boot_go;
    ahb_rsp_t lmem_rsp;
    ahb_rsp_t mbox_rsp;

    // --------------------
    // uC AHB fabric
    ahb_addr_decoder u_decoder (
        .core_clk   (core_clk),
        .rst_n_i    (rst_n_i),
        .ahb_req_i  (ahb_req_i),
        .ahb_rsp_o  (ahb_rsp_o),
        .hready_o   (hready),
        .lmem_sel_o (lmem_sel),
        .mbox_sel_o (mbox_sel),
        .lmem_rsp_i (lmem_rsp),
        .mbox_rsp_i (mbox_rsp)
    );

    ahb_lmem #(
        .LMEM_WORDS (LMEM_WORDS)
    ) u_lmem (
        .core_clk  (core_clk),
        .rst_n_i   (rst_n_i),
        .hsel_i    (lmem_sel),
        .hready_i  (hready),
        .ahb_req_i (ahb_req_i),
        .hwdata_i  (hwdata_i),
        .ahb_rsp_o (lmem_rsp)
    );

    // --------------------
    // Mailbox and boot control
    mbox_regs #(
        .VALID_PAUSER (VALID_PAUSER)
    ) u_mbox (
        .core_clk      (core_clk),
        .rst_n_i       (rst_n_i),
        .apb_req_i     (apb_req_i),
        .apb_rsp_o     (apb_rsp_o),
        .hsel_i        (mbox_sel),
        .hready_i      (hready),
        .ahb_req_i     (ahb_req_i),
        .hwdata_i      (hwdata_i),
        .ahb_rsp_o     (mbox_rsp),
        .boot_go_o     (boot_go),
        .uc_released_i (uc_rst_n_o)
    );

    boot_seq_fsm #(
        .BOOT_DELAY (BOOT_DELAY)
    ) u_boot_fsm (
        .core_clk   (core_clk),
        .rst_n_i    (rst_n_i),
        .boot_go_i  (boot_go),
        .uc_rst_n_o (uc_rst_n_o)
    );

endmodule

/* tb/soc_ifc_checker.sv */
// Mailbox and LMEM reference models, reference function and bus response checking

module soc_ifc_checker #(
    parameter int                             LMEM_WORDS   = 256,
    parameter int                             BOOT_DELAY   = 16,
    parameter logic [soc_ifc_pkg::USER_W-1:0] VALID_PAUSER = 8'h01
) (
    input  logic                           core_clk,
    input  logic                           rst_n_i,
    input  soc_ifc_pkg::apb_req_t          apb_req_i,
    input  soc_ifc_pkg::apb_rsp_t          apb_rsp_i,
    input  soc_ifc_pkg::ahb_req_t          ahb_req_i,
    input  logic [soc_ifc_pkg::DATA_W-1:0] hwdata_i,
    input  soc_ifc_pkg::ahb_rsp_t          ahb_rsp_i,
    input  logic                           uc_rst_n_i,
    output int                             mismatch_cnt_o,
    output int                             check_cnt_o
);
    import soc_ifc_pkg::*;

    logic [31:0] m_cmd;
    logic [31:0] m_data;
    logic [31:0] m_resp;
    logic [31:0] lmem_model [LMEM_WORDS];
    logic        lmem_vld [LMEM_WORDS];
    logic        released;
    logic        booted;
    int          cyc;
    int          boot_cyc;
    logic        dp_valid;
    logic        dp_write;
    logic        dp_second;
    logic [31:0] dp_addr;

    initial begin
        mismatch_cnt_o = 0;
        check_cnt_o    = 0;
    end

    // Expected {error, read data} for one access, from the current model state
    function automatic logic [32:0] ref_access(
        input logic        is_apb,
        input logic        wr,
        input logic [31:0] addr,
        input logic [7:0]  user
    );
        logic [3:0]  off;
        logic        err;
        logic [31:0] rd;
        off = addr[3:0];
        err = 1'b0;
        case (off)
            REG_CMD:  rd = m_cmd;
            REG_DATA: rd = m_data;
            REG_RESP: rd = m_resp;
            REG_BOOT: rd = {31'b0, released};
            default:  rd = '0;
        endcase
        if (is_apb) begin
            if (addr[31:4] != '0 || !(off inside {REG_CMD, REG_DATA, REG_RESP, REG_BOOT})) begin
                err = 1'b1;
                rd  = '0;
            end else if (wr && (off == REG_RESP || user != VALID_PAUSER)) begin
                err = 1'b1;
            end
        end else if (addr[31:16] == LMEM_BASE) begin
            rd = lmem_model[(addr >> 2) % LMEM_WORDS];
        end else if (addr[31:16] != MBOX_BASE) begin
            err = 1'b1;
            rd  = '0;
        end
        return {err, rd};
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt_o = check_cnt_o + 1;
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            mismatch_cnt_o = mismatch_cnt_o + 1;
        end
    endtask

    // --------------------
    // Sampled mid-cycle, where inputs and responses are both settled
    always @(negedge core_clk) begin
        logic [32:0] apb_exp;
        logic [32:0] ahb_exp;
        logic        is_lmem;
        int          idx;
        if (!rst_n_i) begin
            m_cmd    = '0;
            m_data   = '0;
            m_resp   = '0;
            booted   = 1'b0;
            released = 1'b0;
            cyc      = 0;
            boot_cyc = 0;
            dp_valid = 1'b0;
            for (int i = 0; i < LMEM_WORDS; i++) begin
                lmem_vld[i] = 1'b0;
            end
        end else begin
            cyc      = cyc + 1;
            released = booted && (cyc - boot_cyc > BOOT_DELAY);
            compare_word("uc_rst_n_o", uc_rst_n_i, released);

            // APB access phase
            apb_exp = '0;
            if (apb_req_i.psel && apb_req_i.penable) begin
                apb_exp = ref_access(1'b1, apb_req_i.pwrite, apb_req_i.paddr, apb_req_i.pauser);
                compare_word("pready", apb_rsp_i.pready, 32'h1);
                compare_word("pslverr", apb_rsp_i.pslverr, apb_exp[32]);
                if (!apb_req_i.pwrite) begin
                    compare_word("prdata", apb_rsp_i.prdata, apb_exp[31:0]);
                end
            end

            // AHB data phase
            is_lmem = dp_addr[31:16] == LMEM_BASE;
            idx     = (dp_addr >> 2) % LMEM_WORDS;
            ahb_exp = ref_access(1'b0, dp_write, dp_addr, '0);
            if (dp_valid && ahb_exp[32]) begin
                compare_word("hreadyout", ahb_rsp_i.hreadyout, dp_second);
                compare_word("hresp", ahb_rsp_i.hresp, 32'h1);
            end else begin
                compare_word("hreadyout", ahb_rsp_i.hreadyout, 32'h1);
                compare_word("hresp", ahb_rsp_i.hresp, 32'h0);
                if (dp_valid && !dp_write && !(is_lmem && !lmem_vld[idx])) begin
                    compare_word("hrdata", ahb_rsp_i.hrdata, ahb_exp[31:0]);
                end
            end

            // Model updates land at the coming edge
            if (apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite && !apb_exp[32]) begin
                if (apb_req_i.paddr[3:0] == REG_CMD) begin
                    m_cmd = apb_req_i.pwdata;
                end
                if (apb_req_i.paddr[3:0] == REG_DATA) begin
                    m_data = apb_req_i.pwdata;
                end
                if (apb_req_i.paddr[3:0] == REG_BOOT && apb_req_i.pwdata[0] && !booted) begin
                    booted   = 1'b1;
                    boot_cyc = cyc;
                end
            end
            if (dp_valid && dp_write && !ahb_exp[32]) begin
                if (is_lmem) begin
                    lmem_model[idx] = hwdata_i;
                    lmem_vld[idx]   = 1'b1;
                end else if (dp_addr[3:0] == REG_RESP) begin
                    m_resp = hwdata_i;
                end
            end

            // Address phase taken only while the bus is ready
            if (ahb_rsp_i.hreadyout) begin
                dp_valid  = ahb_req_i.htrans[1];
                dp_write  = ahb_req_i.hwrite;
                dp_addr   = ahb_req_i.haddr;
                dp_second = 1'b0;
            end else begin
                dp_second = 1'b1;
            end
        end
    end

endmodule

/* tb/tb_soc_ifc_top.sv */
// Testbench top with clock, reset, APB and AHB drivers, stimulus and watchdog

module tb_soc_ifc_top;
    import soc_ifc_pkg::*;

    localparam int          CLK_PERIOD     = 4;
    localparam int          LMEM_WORDS     = 256;
    localparam int          BOOT_DELAY     = 16;
    localparam logic [7:0]  VALID_PAUSER   = 8'h01;
    localparam logic [31:0] MBOX           = 32'h3000_0000;
    localparam int          N_RAND         = 200;
    localparam int          APB_OPS        = 17;
    localparam int          AHB_OPS        = N_RAND + 16;
    localparam int          PLANNED_CYCLES = 10 + 3 * APB_OPS + AHB_OPS + BOOT_DELAY + 8;

    logic              core_clk;
    logic              rst_n;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;
    ahb_req_t          ahb_req;
    logic [DATA_W-1:0] hwdata;
    logic [DATA_W-1:0] next_hwdata;
    ahb_rsp_t          ahb_rsp;
    logic              uc_rst_n;
    int                mismatch_cnt;
    int                check_cnt;
    int                other_errs;
    int unsigned       seed_val;

    soc_ifc_top DUT (
        .core_clk   (core_clk),
        .rst_n_i    (rst_n),
        .apb_req_i  (apb_req),
        .apb_rsp_o  (apb_rsp),
        .ahb_req_i  (ahb_req),
        .hwdata_i   (hwdata),
        .ahb_rsp_o  (ahb_rsp),
        .uc_rst_n_o (uc_rst_n)
    );

    soc_ifc_checker #(
        .LMEM_WORDS   (LMEM_WORDS),
        .BOOT_DELAY   (BOOT_DELAY),
        .VALID_PAUSER (VALID_PAUSER)
    ) u_checker (
        .core_clk       (core_clk),
        .rst_n_i        (rst_n),
        .apb_req_i      (apb_req),
        .apb_rsp_i      (apb_rsp),
        .ahb_req_i      (ahb_req),
        .hwdata_i       (hwdata),
        .ahb_rsp_i      (ahb_rsp),
        .uc_rst_n_i     (uc_rst_n),
        .mismatch_cnt_o (mismatch_cnt),
        .check_cnt_o    (check_cnt)
    );

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    // --------------------
    // Bus drivers called just after a rising edge
    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] data, input logic [7:0] user);
        apb_req.paddr   = addr;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = data;
        apb_req.pauser  = user;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge core_clk);
        #1;
        apb_req.penable = 1'b1;
        @(posedge core_clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    // Holds the address phase until an edge with hreadyout high
    task automatic ahb_wait_ready();
        logic ready;
        ready = 1'b0;
        while (!ready) begin
            @(negedge core_clk);
            ready = ahb_rsp.hreadyout;
            @(posedge core_clk);
            #1;
        end
    endtask

    // Address phase of one transfer overlapping the data phase of the previous one
    task automatic ahb_issue(input logic [1:0] trans, input logic wr,
                             input logic [31:0] addr, input logic [31:0] wd);
        ahb_req.haddr  = addr;
        ahb_req.htrans = trans;
        ahb_req.hwrite = wr;
        hwdata         = next_hwdata;
        next_hwdata    = wd;
        ahb_wait_ready();
    endtask

    task automatic ahb_idle();
        ahb_issue(2'b00, 1'b0, '0, '0);
    endtask

    task automatic wait_boot_release();
        int waited;
        waited = 0;
        while (!uc_rst_n && waited < BOOT_DELAY + 8) begin
            @(posedge core_clk);
            #1;
            waited++;
        end
        if (!uc_rst_n) begin
            $display("Boot sequencer never released the microcontroller reset");
            other_errs++;
        end
    endtask

    // Watchdog sized from the planned cycle count
    initial begin
        #(4 * PLANNED_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, the run exceeded its planned length");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed_val    = $urandom(32'h75a2_9606);
        other_errs  = 0;
        apb_req     = '0;
        ahb_req     = '0;
        hwdata      = '0;
        next_hwdata = '0;
        rst_n       = 1'b0;
        repeat (10) @(posedge core_clk);
        #1;
        rst_n = 1'b1;

        // Reset values
        for (int i = 0; i < 4; i++) begin
            apb_access(1'b0, 32'(i * 4), '0, VALID_PAUSER);
        end

        // Mailbox traffic in both directions
        apb_access(1'b1, REG_CMD, 32'hc0de_0001, VALID_PAUSER);
        apb_access(1'b1, REG_DATA, 32'hdead_beef, VALID_PAUSER);
        ahb_issue(HTRANS_NONSEQ, 1'b0, MBOX + REG_CMD, '0);
        ahb_issue(HTRANS_NONSEQ, 1'b0, MBOX + REG_DATA, '0);
        ahb_issue(HTRANS_NONSEQ, 1'b1, MBOX + REG_RESP, 32'h1234_5678);
        ahb_issue(HTRANS_NONSEQ, 1'b1, MBOX + REG_CMD, 32'hffff_ffff);
        ahb_issue(HTRANS_NONSEQ, 1'b0, MBOX + REG_CMD, '0);
        ahb_idle();
        apb_access(1'b0, REG_RESP, '0, VALID_PAUSER);
        apb_access(1'b0, REG_CMD, '0, VALID_PAUSER);

        // Slave errors
        apb_access(1'b1, REG_CMD, 32'hbad0_0001, 8'h02);
        apb_access(1'b1, 32'h0000_0010, 32'hbad0_0002, VALID_PAUSER);
        apb_access(1'b1, 32'h0000_0006, 32'hbad0_0004, VALID_PAUSER);
        apb_access(1'b1, REG_RESP, 32'hbad0_0003, VALID_PAUSER);
        apb_access(1'b0, REG_CMD, '0, VALID_PAUSER);
        apb_access(1'b0, REG_RESP, '0, VALID_PAUSER);

        // --------------------
        // Boot release
        apb_access(1'b1, REG_BOOT, 32'h1, VALID_PAUSER);
        wait_boot_release();
        apb_access(1'b1, REG_BOOT, 32'h1, VALID_PAUSER);
        apb_access(1'b0, REG_BOOT, '0, VALID_PAUSER);
        ahb_issue(HTRANS_NONSEQ, 1'b0, MBOX + REG_BOOT, '0);
        ahb_idle();

        // Random pipelined LMEM traffic over an index range wider than the memory
        for (int i = 0; i < N_RAND; i++) begin
            ahb_issue(($urandom % 2) ? HTRANS_NONSEQ : 2'b11, 1'($urandom % 2),
                      32'(($urandom % (2 * LMEM_WORDS)) << 2), $urandom);
        end
        ahb_idle();

        // Unmapped address followed by a normal transfer
        ahb_issue(HTRANS_NONSEQ, 1'b0, 32'h5000_0000, '0);
        ahb_issue(HTRANS_NONSEQ, 1'b1, 32'h0000_0040, 32'h0bad_cafe);
        ahb_issue(HTRANS_NONSEQ, 1'b0, 32'h0000_0040, '0);
        ahb_idle();

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_cnt, mismatch_cnt, other_errs);
        if (mismatch_cnt == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* soc_ifc_top.f */
source/soc_ifc_pkg.sv
source/ahb_addr_decoder.sv
source/ahb_lmem.sv
source/mbox_regs.sv
source/boot_seq_fsm.sv
source/soc_ifc_top.sv
tb/soc_ifc_checker.sv
tb/tb_soc_ifc_top.sv
